// ==== src/env_step_pkg.sv ====
`default_nettype none

package env_step_pkg;

    localparam int DATA_WL      = 32;   // memory word
    localparam int ADDR_WL      = 6;    // word address
    localparam int RWD_WL       = 2;    // reward bits per env
    localparam int STEP_LATENCY = 2;    // launch to valid in a PE
    localparam int POS_LIMIT    = 1000; // |pos| above this ends the episode
    localparam int CLR_FLAG     = 2;    // flag value forcing a reload

    // one environment, exactly one memory word
    typedef struct packed {
        logic signed [15:0] pos;
        logic signed [15:0] vel;
    } env_state_t;

    typedef struct packed {
        env_state_t        state; // state after the step
        logic [RWD_WL-1:0] rwd;
        logic              done;
    } step_res_t;

    typedef struct packed {
        logic [ADDR_WL-1:0] addr;
        logic [DATA_WL-1:0] wdata;
        logic               we;
    } mem_req_t;

    typedef struct packed {
        logic load_sta;     // shift one state in
        logic load_act;     // capture action word
        logic commit_batch; // rotate by PE_NUM, insert results
        logic emit_one;     // rotate by one
    } buf_ctrl_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_STA,
        LOAD_ACT,
        STEP,
        STORE_OBS,
        STORE_RWD,
        STORE_DONE,
        CLEAR
    } seq_state_e;

endpackage

`default_nettype wire

// ==== src/step_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_pe (
    input  wire                           i_clk,
    input  wire                           i_rstn,
    input  wire                           i_launch,
    input  wire env_step_pkg::env_state_t i_state,
    input  wire                           i_act,
    output env_step_pkg::step_res_t       o_res,
    output logic                          o_valid
);
    import env_step_pkg::*;

    logic               valid1;
    logic signed [15:0] pos1;    // old position
    logic signed [15:0] vel1;    // new velocity
    logic signed [15:0] pos_new;
    logic               done_new;

    // stage one, push the velocity by the action
    always_ff @(posedge i_clk) begin
        if (i_launch) begin
            pos1 <= i_state.pos;
            vel1 <= i_act ? (i_state.vel + 16'sd1) : (i_state.vel - 16'sd1);
        end
    end

    assign pos_new  = pos1 + vel1;
    assign done_new = (pos_new > POS_LIMIT) || (pos_new < -POS_LIMIT);

    // stage two, integrate and judge
    always_ff @(posedge i_clk) begin
        if (valid1) begin
            o_res.state.pos <= pos_new;
            o_res.state.vel <= vel1;
            o_res.rwd       <= done_new ? '0 : RWD_WL'(1);
            o_res.done      <= done_new;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            valid1  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid1  <= i_launch;
            o_valid <= valid1;
        end
    end

endmodule

`default_nettype wire

// ==== src/state_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module state_buffer #(
    parameter int N_ENV  = 16,
    parameter int PE_NUM = 4
) (
    input  wire                                       i_clk,
    input  wire                                       i_rstn,
    input  wire env_step_pkg::buf_ctrl_t              i_ctrl,
    input  wire [env_step_pkg::DATA_WL-1:0]           i_mem_rdata,
    input  wire env_step_pkg::step_res_t [PE_NUM-1:0] i_res,
    output env_step_pkg::env_state_t [PE_NUM-1:0]     o_pe_state,
    output logic [PE_NUM-1:0]                         o_pe_act,
    output env_step_pkg::env_state_t                  o_head_state
);
    import env_step_pkg::*;

    env_state_t       sta [N_ENV]; // index 0 is the head
    logic [N_ENV-1:0] act;         // bit 0 belongs to the head

    // indices taken modulo N_ENV or PE_NUM stay in range for every slot
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N_ENV; i++) begin
            if (i_ctrl.load_sta) begin
                sta[i] <= (i == N_ENV - 1) ? env_state_t'(i_mem_rdata) : sta[(i + 1) % N_ENV];
            end else if (i_ctrl.commit_batch) begin
                sta[i] <= (i < N_ENV - PE_NUM) ? sta[(i + PE_NUM) % N_ENV]
                                               : i_res[i % PE_NUM].state;
            end else if (i_ctrl.emit_one) begin
                sta[i] <= sta[(i + 1) % N_ENV]; // rotate so states survive the store
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            act <= '0;
        end else if (i_ctrl.load_act) begin
            act <= i_mem_rdata[N_ENV-1:0];
        end else if (i_ctrl.commit_batch) begin
            for (int i = 0; i < N_ENV; i++) begin
                act[i] <= act[(i + PE_NUM) % N_ENV]; // follows the states
            end
        end
    end

    always_comb begin
        for (int j = 0; j < PE_NUM; j++) begin
            o_pe_state[j] = sta[j];
        end
    end

    assign o_pe_act     = act[PE_NUM-1:0];
    assign o_head_state = sta[0];

    a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0(i_ctrl))
        else $error("more than one buffer strobe active");

endmodule

`default_nettype wire

// ==== src/result_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_packer #(
    parameter int N_ENV  = 16,
    parameter int PE_NUM = 4
) (
    input  wire                                       i_clk,
    input  wire                                       i_rstn,
    input  wire                                       i_valid,
    input  wire env_step_pkg::step_res_t [PE_NUM-1:0] i_res,
    output logic [env_step_pkg::DATA_WL-1:0]          o_rwd_word,
    output logic [env_step_pkg::DATA_WL-1:0]          o_done_word
);
    import env_step_pkg::*;

    logic [RWD_WL-1:0] rwd_q [N_ENV];
    logic [N_ENV-1:0]  done_q;

    // each batch enters at the top, so batch 0 ends at env 0
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < N_ENV; i++) begin
                rwd_q[i] <= '0;
            end
            done_q <= '0;
        end else if (i_valid) begin
            for (int i = 0; i < N_ENV; i++) begin
                rwd_q[i]  <= (i < N_ENV - PE_NUM) ? rwd_q[(i + PE_NUM) % N_ENV]
                                                  : i_res[i % PE_NUM].rwd;
                done_q[i] <= (i < N_ENV - PE_NUM) ? done_q[(i + PE_NUM) % N_ENV]
                                                  : i_res[i % PE_NUM].done;
            end
        end
    end

    always_comb begin
        o_rwd_word = '0; // unused high bits
        for (int i = 0; i < N_ENV; i++) begin
            o_rwd_word[i*RWD_WL +: RWD_WL] = rwd_q[i];
        end
    end

    assign o_done_word = DATA_WL'(done_q);

endmodule

`default_nettype wire

// ==== src/step_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_sequencer #(
    parameter int N_ENV  = 16,
    parameter int PE_NUM = 4
) (
    input  wire                              i_clk,
    input  wire                              i_rstn,
    input  wire [env_step_pkg::DATA_WL-1:0]  i_mem_rdata,
    input  wire env_step_pkg::env_state_t    i_head_state,
    input  wire                              i_pe_valid,
    input  wire [env_step_pkg::DATA_WL-1:0]  i_rwd_word,
    input  wire [env_step_pkg::DATA_WL-1:0]  i_done_word,
    output env_step_pkg::mem_req_t           o_mem_req,
    output env_step_pkg::buf_ctrl_t          o_buf_ctrl,
    output logic                             o_launch
);
    import env_step_pkg::*;

    // memory map, all in words
    localparam int ACT_ADDR  = N_ENV;
    localparam int FLAG_ADDR = N_ENV + 1;
    localparam int OBS_ADDR  = N_ENV + 2;
    localparam int RWD_ADDR  = OBS_ADDR + N_ENV;
    localparam int DONE_ADDR = RWD_ADDR + 1;
    localparam int MAP_END   = DONE_ADDR + 1;
    localparam int N_BATCH   = N_ENV / PE_NUM;

    seq_state_e         state, state_n;
    logic               idle_q;   // was idle last cycle, so rdata holds the flag
    logic               loaded;   // buffer holds valid states
    logic               rd_sta_q; // state word arrives this cycle
    logic               rd_act_q; // action word arrives this cycle
    logic               busy;     // batch in flight
    logic [ADDR_WL-1:0] env_cnt;
    logic [ADDR_WL-1:0] bat_cnt;

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (idle_q && i_mem_rdata != '0) begin
                    if (i_mem_rdata == DATA_WL'(CLR_FLAG) || !loaded) begin
                        state_n = LOAD_STA;
                    end else begin
                        state_n = LOAD_ACT;
                    end
                end
            end
            LOAD_STA:   if (env_cnt == ADDR_WL'(N_ENV - 1)) state_n = LOAD_ACT;
            LOAD_ACT:   if (rd_act_q) state_n = STEP;
            STEP:       if (i_pe_valid && bat_cnt == ADDR_WL'(N_BATCH - 1)) state_n = STORE_OBS;
            STORE_OBS:  if (env_cnt == ADDR_WL'(N_ENV - 1)) state_n = STORE_RWD;
            STORE_RWD:  state_n = STORE_DONE;
            STORE_DONE: state_n = CLEAR;
            CLEAR:      state_n = IDLE;
            default:    state_n = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state    <= IDLE;
            idle_q   <= 1'b0;
            loaded   <= 1'b0;
            rd_sta_q <= 1'b0;
            rd_act_q <= 1'b0;
            busy     <= 1'b0;
            env_cnt  <= '0;
            bat_cnt  <= '0;
        end else begin
            state    <= state_n;
            idle_q   <= (state == IDLE);
            rd_sta_q <= (state == LOAD_STA);
            rd_act_q <= (state == LOAD_ACT) && !rd_act_q; // two-cycle action fetch
            if (state == LOAD_STA && state_n != LOAD_STA) begin
                loaded <= 1'b1;
            end
            if (state != state_n) begin
                env_cnt <= '0;
            end else if (state == LOAD_STA || state == STORE_OBS) begin
                env_cnt <= env_cnt + 1'b1;
            end
            if (o_launch) begin
                busy <= 1'b1;
            end else if (i_pe_valid) begin
                busy <= 1'b0;
            end
            if (state != STEP) begin
                bat_cnt <= '0;
            end else if (i_pe_valid) begin
                bat_cnt <= bat_cnt + 1'b1;
            end
        end
    end

    // next launch only once the previous batch is committed
    assign o_launch = (state == STEP) && !busy;

    assign o_buf_ctrl.load_sta     = rd_sta_q;
    assign o_buf_ctrl.load_act     = rd_act_q;
    assign o_buf_ctrl.commit_batch = (state == STEP) && i_pe_valid;
    assign o_buf_ctrl.emit_one     = (state == STORE_OBS);

    always_comb begin
        o_mem_req.wdata = '0;
        o_mem_req.we    = 1'b0;
        case (state)
            LOAD_STA:   o_mem_req.addr = env_cnt;
            LOAD_ACT:   o_mem_req.addr = ADDR_WL'(ACT_ADDR);
            STORE_OBS: begin
                o_mem_req.addr  = ADDR_WL'(OBS_ADDR) + env_cnt;
                o_mem_req.wdata = i_head_state;
                o_mem_req.we    = 1'b1;
            end
            STORE_RWD: begin
                o_mem_req.addr  = ADDR_WL'(RWD_ADDR);
                o_mem_req.wdata = i_rwd_word;
                o_mem_req.we    = 1'b1;
            end
            STORE_DONE: begin
                o_mem_req.addr  = ADDR_WL'(DONE_ADDR);
                o_mem_req.wdata = i_done_word;
                o_mem_req.we    = 1'b1;
            end
            CLEAR: begin
                o_mem_req.addr = ADDR_WL'(FLAG_ADDR); // flag back to zero
                o_mem_req.we   = 1'b1;
            end
            default:    o_mem_req.addr = ADDR_WL'(FLAG_ADDR); // poll the flag
        endcase
    end

    a_we_legal: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_mem_req.we |-> state inside {STORE_OBS, STORE_RWD, STORE_DONE, CLEAR})
        else $error("write outside a store state");

    a_addr_in_map: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_mem_req.addr < ADDR_WL'(MAP_END))
        else $error("address beyond the memory map");

    // PE row must answer exactly STEP_LATENCY cycles after launch
    a_pe_latency: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_launch |-> ##STEP_LATENCY i_pe_valid)
        else $error("PE valid missing after launch");

endmodule

`default_nettype wire

// ==== src/env_step_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module env_step_top #(
    parameter int N_ENV  = 16,
    parameter int PE_NUM = 4
) (
    input  wire                              i_clk,
    input  wire                              i_rstn,
    input  wire [env_step_pkg::DATA_WL-1:0]  i_mem_rdata,
    output env_step_pkg::mem_req_t           o_mem_req
);
    import env_step_pkg::*;

    buf_ctrl_t                 buf_ctrl;
    env_state_t                head_state;
    env_state_t [PE_NUM-1:0]   pe_state;
    logic       [PE_NUM-1:0]   pe_act;
    step_res_t  [PE_NUM-1:0]   pe_res;
    logic       [PE_NUM-1:0]   pe_valid;    // all lanes run in lockstep
    logic                      launch;
    logic       [DATA_WL-1:0]  rwd_word;
    logic       [DATA_WL-1:0]  done_word;

    step_sequencer #(.N_ENV(N_ENV), .PE_NUM(PE_NUM)) u_seq (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_mem_rdata  (i_mem_rdata),
        .i_head_state (head_state),
        .i_pe_valid   (&pe_valid),
        .i_rwd_word   (rwd_word),
        .i_done_word  (done_word),
        .o_mem_req    (o_mem_req),
        .o_buf_ctrl   (buf_ctrl),
        .o_launch     (launch)
    );

    state_buffer #(.N_ENV(N_ENV), .PE_NUM(PE_NUM)) u_buf (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_ctrl       (buf_ctrl),
        .i_mem_rdata  (i_mem_rdata),
        .i_res        (pe_res),
        .o_pe_state   (pe_state),
        .o_pe_act     (pe_act),
        .o_head_state (head_state)
    );

    for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
        step_pe u_pe (
            .i_clk    (i_clk),
            .i_rstn   (i_rstn),
            .i_launch (launch),
            .i_state  (pe_state[g]),
            .i_act    (pe_act[g]),
            .o_res    (pe_res[g]),
            .o_valid  (pe_valid[g])
        );
    end

    result_packer #(.N_ENV(N_ENV), .PE_NUM(PE_NUM)) u_pack (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_valid     (&pe_valid),
        .i_res       (pe_res),
        .o_rwd_word  (rwd_word),
        .o_done_word (done_word)
    );

endmodule

`default_nettype wire

// ==== sim/env_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module env_mem_model (
    input  wire                              i_clk,
    input  wire env_step_pkg::mem_req_t      i_req,
    output logic [env_step_pkg::DATA_WL-1:0] o_rdata
);
    import env_step_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WL;

    logic [DATA_WL-1:0] mem [DEPTH];

    initial begin
        o_rdata = '0;
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = {8'h5a, 2'b00, 6'(a), 10'h2c3, ~6'(a)}; // every address bit shows
        end
    end

    // one cycle read latency, read returns the old word on a write
    always @(posedge i_clk) begin
        o_rdata <= mem[i_req.addr];
        if (i_req.we) begin
            mem[i_req.addr] <= i_req.wdata;
        end
    end

    // host side access, bypasses the port
    task write_word(input logic [ADDR_WL-1:0] addr, input logic [DATA_WL-1:0] data);
        mem[addr] = data;
    endtask

    task read_word(input logic [ADDR_WL-1:0] addr, output logic [DATA_WL-1:0] data);
        data = mem[addr];
    endtask

endmodule

`default_nettype wire

// ==== sim/env_step_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module env_step_tb;
    import env_step_pkg::*;

    localparam int N_ENV      = 16;
    localparam int PE_NUM     = 4;
    localparam int ACT_ADDR   = N_ENV;
    localparam int FLAG_ADDR  = N_ENV + 1;
    localparam int OBS_ADDR   = N_ENV + 2;
    localparam int RWD_ADDR   = OBS_ADDR + N_ENV;
    localparam int DONE_ADDR  = RWD_ADDR + 1;
    localparam int MEM_DEPTH  = 2 ** ADDR_WL;
    localparam int STEP_CYCLES  = 3 * N_ENV + 20;
    localparam int LIMIT_CYCLES = 6 * STEP_CYCLES + 300; // six scenarios plus slack

    logic               i_clk;
    logic               i_rstn;
    mem_req_t           mem_req;
    logic [DATA_WL-1:0] mem_rdata;

    int         errors;
    int         checks;
    int         clear_cnt;         // flag clears seen so far
    env_state_t ref_sta  [N_ENV];  // states the DUT should hold
    env_state_t host_sta [N_ENV];  // states last written to memory

    env_step_top #(.N_ENV(N_ENV), .PE_NUM(PE_NUM)) i_dut (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_mem_rdata (mem_rdata),
        .o_mem_req   (mem_req)
    );

    env_mem_model u_mem (
        .i_clk   (i_clk),
        .i_req   (mem_req),
        .o_rdata (mem_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // point mass rule, done when |pos| exceeds the limit
    function automatic step_res_t expected_step(input env_state_t s, input logic act);
        step_res_t r;
        int        p;
        r.state.vel = act ? (s.vel + 16'sd1) : (s.vel - 16'sd1);
        r.state.pos = s.pos + r.state.vel;
        p = $signed(r.state.pos);
        r.done = (p > POS_LIMIT) || (p < -POS_LIMIT);
        r.rwd  = r.done ? 2'd0 : 2'd1;
        return r;
    endfunction

    task automatic compare_word(input string label, input logic [DATA_WL-1:0] exp,
                                input logic [DATA_WL-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", label, exp, act);
        end
    endtask

    // a flag write marks the end of a step, counted once it has landed
    always begin
        @(negedge i_clk);
        if (i_rstn && mem_req.we && mem_req.addr == ADDR_WL'(FLAG_ADDR)) begin
            @(posedge i_clk);
            #1;
            clear_cnt++;
        end
    end

    task automatic write_states();
        @(posedge i_clk);
        #1;
        for (int i = 0; i < N_ENV; i++) begin
            u_mem.write_word(ADDR_WL'(i), host_sta[i]);
        end
    endtask

    task automatic do_step(input string name, input logic [N_ENV-1:0] act,
                           input logic [DATA_WL-1:0] flag, input bit reload);
        step_res_t          r;
        logic [DATA_WL-1:0] got;
        logic [DATA_WL-1:0] exp_rwd;
        logic [DATA_WL-1:0] exp_done;
        int                 target;
        exp_rwd  = '0;
        exp_done = '0;
        if (reload) begin
            for (int i = 0; i < N_ENV; i++) begin
                ref_sta[i] = host_sta[i];
            end
        end
        target = clear_cnt + 1;
        @(posedge i_clk);
        #1;
        u_mem.write_word(ADDR_WL'(ACT_ADDR), DATA_WL'(act));
        u_mem.write_word(ADDR_WL'(FLAG_ADDR), flag); // DUT is idle here
        wait (clear_cnt == target);
        for (int i = 0; i < N_ENV; i++) begin
            r = expected_step(ref_sta[i], act[i]);
            exp_rwd[i*RWD_WL +: RWD_WL] = r.rwd;
            exp_done[i] = r.done;
            u_mem.read_word(ADDR_WL'(OBS_ADDR + i), got);
            compare_word($sformatf("%s obs %0d", name, i), r.state, got);
            ref_sta[i] = r.state;
        end
        u_mem.read_word(ADDR_WL'(RWD_ADDR), got);
        compare_word({name, " reward word"}, exp_rwd, got);
        u_mem.read_word(ADDR_WL'(DONE_ADDR), got);
        compare_word({name, " done word"}, exp_done, got);
        u_mem.read_word(ADDR_WL'(FLAG_ADDR), got);
        compare_word({name, " flag"}, '0, got);
    endtask

    initial begin
        logic [DATA_WL-1:0] snap [MEM_DEPTH];
        logic [DATA_WL-1:0] got;
        logic [DATA_WL-1:0] rnd;
        logic [N_ENV-1:0]   act;
        rnd       = $urandom(32'h8425ca27);
        i_rstn    = 1'b0;
        errors    = 0;
        checks    = 0;
        clear_cnt = 0;
        @(posedge i_clk);
        #1;
        u_mem.write_word(ADDR_WL'(FLAG_ADDR), '0);
        repeat (2) @(posedge i_clk);
        #1;
        i_rstn = 1'b1;

        // 1: idle with flag zero
        for (int a = 0; a < MEM_DEPTH; a++) begin
            u_mem.read_word(ADDR_WL'(a), snap[a]);
        end
        repeat (20) begin
            @(negedge i_clk);
            if (mem_req.we) begin
                errors++;
                $display("write request seen while the flag is zero");
            end
        end
        for (int a = 0; a < MEM_DEPTH; a++) begin
            u_mem.read_word(ADDR_WL'(a), got);
            compare_word($sformatf("s1 mem %0d", a), snap[a], got);
        end

        // 2: first step loads the states
        for (int i = 0; i < N_ENV; i++) begin
            host_sta[i].pos = 16'(int'($urandom_range(1000)) - 500);
            host_sta[i].vel = 16'(int'($urandom_range(40)) - 20);
        end
        write_states();
        rnd = $urandom;
        do_step("s2", rnd[N_ENV-1:0], 32'd1, 1'b1);

        // 3: garbage in memory, held states must be used
        @(posedge i_clk);
        #1;
        for (int i = 0; i < N_ENV; i++) begin
            u_mem.write_word(ADDR_WL'(i), $urandom);
        end
        rnd = $urandom;
        do_step("s3", rnd[N_ENV-1:0], 32'd1, 1'b0);

        // 4: CLR forces a reload of new states
        for (int i = 0; i < N_ENV; i++) begin
            host_sta[i].pos = 16'(int'($urandom_range(1000)) - 500);
            host_sta[i].vel = 16'(int'($urandom_range(40)) - 20);
        end
        write_states();
        rnd = $urandom;
        do_step("s4", rnd[N_ENV-1:0], DATA_WL'(CLR_FLAG), 1'b1);

        // 5: states at the position bound, outward and inward
        for (int i = 0; i < N_ENV; i++) begin
            case (i % 4)
                0: begin
                    host_sta[i].pos = 16'sd998;
                    host_sta[i].vel = 16'sd2;
                    act[i]          = 1'b1;   // lands at 1001
                end
                1: begin
                    host_sta[i].pos = -16'sd997;
                    host_sta[i].vel = -16'sd2;
                    act[i]          = 1'b0;   // lands exactly on -1000
                end
                2: begin
                    host_sta[i].pos = 16'sd999;
                    host_sta[i].vel = -16'sd1;
                    act[i]          = 1'b0;   // moving inward
                end
                default: begin
                    host_sta[i].pos = -16'sd999;
                    host_sta[i].vel = -16'sd1;
                    act[i]          = 1'b0;
                end
            endcase
        end
        write_states();
        do_step("s5", act, DATA_WL'(CLR_FLAG), 1'b1);

        // 6: chained steps on held states
        for (int k = 0; k < 3; k++) begin
            rnd = $urandom;
            do_step($sformatf("s6 step %0d", k), rnd[N_ENV-1:0], 32'd1, 1'b0);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge i_clk);
        $display("timeout, the DUT did not finish all steps within %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/env_step_pkg.sv
src/step_pe.sv
src/state_buffer.sv
src/result_packer.sv
src/step_sequencer.sv
src/env_step_top.sv
sim/env_mem_model.sv
sim/env_step_tb.sv
